// ==== hdl/axi_rd_settings.svh ====
`ifndef AXI_RD_SETTINGS_SVH
`define AXI_RD_SETTINGS_SVH

// Address bus width
`define AXI_RD_ADDR_W 32

// Data bus width, also sets the AR size field
`define AXI_RD_DATA_W 32

// Burst length field, value is beats minus one
`define AXI_RD_LEN_W 8

// Read ID width
`define AXI_RD_ID_W 4

`endif

// ==== hdl/axi_rd_pkg.sv ====
`default_nettype none

`include "axi_rd_settings.svh"

package axi_rd_pkg;

   // Bridge control states
   typedef enum logic {
      st_addr = 1'b0,
      st_read = 1'b1
   } ctrl_state_e;

   // AXI burst type encoding
   typedef enum logic [1:0] {
      burst_fixed = 2'd0,
      burst_incr  = 2'd1,
      burst_wrap  = 2'd2
   } axi_burst_e;

   // Read address channel payload
   typedef struct packed {
      logic [`AXI_RD_ID_W-1:0]   id;
      logic [`AXI_RD_ADDR_W-1:0] addr;
      logic [`AXI_RD_LEN_W-1:0]  len;
      logic [2:0]                size;
      axi_burst_e                burst;
      logic                      lock;
      logic [3:0]                cache;
      logic [2:0]                prot;
      logic [3:0]                qos;
   } axi_ar_t;

   // Read data channel payload
   // Response and ID are not tracked by the bridge
   typedef struct packed {
      logic [`AXI_RD_DATA_W-1:0] data;
      logic                      last;
   } axi_r_t;

endpackage

`default_nettype wire

// ==== hdl/axi_rd_ctrl.sv ====
`timescale 1ns/1ps
`default_nettype none

module axi_rd_ctrl (
   input  logic clk,
   input  logic rst,
   input  logic s_valid,
   input  logic m_rvalid,
   input  logic final_beat,
   output logic capture,
   output logic issue,
   output logic beat,
   output logic s_ready,
   output logic m_rready,
   output logic ready
);

   axi_rd_pkg::ctrl_state_e state;
   axi_rd_pkg::ctrl_state_e state_nxt;
   logic                    in_addr;
   logic                    in_read;

   assign in_addr = (state == axi_rd_pkg::st_addr);
   assign in_read = (state == axi_rd_pkg::st_read);

   // Address phase keeps the request payload open
   assign capture = in_addr;

   // A request goes out as soon as the client asserts s_valid
   assign issue = in_addr & s_valid;

   // Data pass-through, both directions combinational
   assign s_ready  = in_read & m_rvalid;
   assign m_rready = in_read & s_valid;

   // Beat counts only when both sides are ready
   assign beat = in_read & m_rvalid & s_valid;

   // Next state
   always_comb begin
      state_nxt = state;
      case (state)
         axi_rd_pkg::st_addr: begin
            if (s_valid) begin
               state_nxt = axi_rd_pkg::st_read;
            end
         end
         axi_rd_pkg::st_read: begin
            if (final_beat) begin
               state_nxt = axi_rd_pkg::st_addr;
            end
         end
         default: begin
            state_nxt = axi_rd_pkg::st_addr;
         end
      endcase
   end

   // State and ready registers
   // ready tracks the state we are about to enter
   always_ff @(posedge clk, posedge rst) begin
      if (rst) begin
         state <= axi_rd_pkg::st_addr;
         ready <= 1'b1;
      end else begin
         state <= state_nxt;
         ready <= (state_nxt == axi_rd_pkg::st_addr);
      end
   end

endmodule

`default_nettype wire

// ==== hdl/axi_ar_channel.sv ====
`timescale 1ns/1ps
`default_nettype none

`include "axi_rd_settings.svh"

module axi_ar_channel (
   input  logic                      clk,
   input  logic                      rst,
   input  logic                      capture,
   input  logic                      issue,
   input  logic [`AXI_RD_ADDR_W-1:0] s_addr,
   input  logic [`AXI_RD_LEN_W-1:0]  length,
   input  logic                      m_arready,
   output axi_rd_pkg::axi_ar_t       m_ar,
   output logic                      m_arvalid,
   output logic [`AXI_RD_LEN_W-1:0]  len_q
);

   // Full-width transfers only
   localparam int unsigned ar_size = $clog2(`AXI_RD_DATA_W / 8);

   logic [`AXI_RD_ADDR_W-1:0] addr_q;
   logic                      arvalid_q;

   // Sample request fields through the whole address phase
   always_ff @(posedge clk) begin
      if (capture) begin
         addr_q <= s_addr;
         len_q  <= length;
      end
   end

   // Live fields in the issue cycle, registered copy afterwards
   always_comb begin
      m_ar       = '0;
      m_ar.id    = '0;
      m_ar.addr  = capture ? s_addr : addr_q;
      m_ar.len   = capture ? length : len_q;
      m_ar.size  = 3'(ar_size);
      m_ar.burst = axi_rd_pkg::burst_incr;
      m_ar.lock  = 1'b0;
      m_ar.cache = 4'd2;
      m_ar.prot  = 3'd2;
      m_ar.qos   = 4'd0;
   end

   // Hold valid until the slave takes the address
   always_ff @(posedge clk, posedge rst) begin
      if (rst) begin
         arvalid_q <= 1'b0;
      end else if (issue) begin
         arvalid_q <= ~m_arready;
      end else if (m_arready) begin
         arvalid_q <= 1'b0;
      end
   end

   // First cycle comes straight from issue
   assign m_arvalid = issue | arvalid_q;

endmodule

`default_nettype wire

// ==== hdl/axi_rd_beat_tracker.sv ====
`timescale 1ns/1ps
`default_nettype none

`include "axi_rd_settings.svh"

module axi_rd_beat_tracker (
   input  logic                     clk,
   input  logic                     rst,
   input  logic                     issue,
   input  logic                     beat,
   input  logic [`AXI_RD_LEN_W-1:0] len_q,
   input  logic                     rlast,
   output logic                     final_beat,
   output logic                     error
);

   logic [`AXI_RD_LEN_W-1:0] count;

   // Beats accepted so far in the current burst
   always_ff @(posedge clk, posedge rst) begin
      if (rst) begin
         count <= '0;
      end else if (issue) begin
         count <= '0;
      end else if (beat) begin
         count <= count + 1'b1;
      end
   end

   // Length field is beats minus one, so compare before increment
   assign final_beat = beat & (count == len_q);

   // Early or missing rlast both show up on the last counted beat
   always_ff @(posedge clk, posedge rst) begin
      if (rst) begin
         error <= 1'b0;
      end else if (final_beat) begin
         error <= ~rlast;
      end
   end

endmodule

`default_nettype wire

// ==== hdl/axi_rd_bridge.sv ====
`timescale 1ns/1ps
`default_nettype none

`include "axi_rd_settings.svh"

module axi_rd_bridge (
   input  logic                      clk,
   input  logic                      rst,
   // Native client port
   input  logic [`AXI_RD_LEN_W-1:0]  length,
   input  logic                      s_valid,
   input  logic [`AXI_RD_ADDR_W-1:0] s_addr,
   output logic                      ready,
   output logic                      error,
   output logic [`AXI_RD_DATA_W-1:0] s_rdata,
   output logic                      s_ready,
   // AXI4 master read port
   output axi_rd_pkg::axi_ar_t       m_ar,
   output logic                      m_arvalid,
   input  logic                      m_arready,
   input  axi_rd_pkg::axi_r_t        m_r,
   input  logic                      m_rvalid,
   output logic                      m_rready
);

   logic                     capture;
   logic                     issue;
   logic                     beat;
   logic                     final_beat;
   logic [`AXI_RD_LEN_W-1:0] len_q;

   // Read data goes to the client untouched
   assign s_rdata = m_r.data;

   axi_rd_ctrl i_axi_rd_ctrl (
      .clk        (clk),
      .rst        (rst),
      .s_valid    (s_valid),
      .m_rvalid   (m_rvalid),
      .final_beat (final_beat),
      .capture    (capture),
      .issue      (issue),
      .beat       (beat),
      .s_ready    (s_ready),
      .m_rready   (m_rready),
      .ready      (ready)
   );

   axi_ar_channel i_axi_ar_channel (
      .clk       (clk),
      .rst       (rst),
      .capture   (capture),
      .issue     (issue),
      .s_addr    (s_addr),
      .length    (length),
      .m_arready (m_arready),
      .m_ar      (m_ar),
      .m_arvalid (m_arvalid),
      .len_q     (len_q)
   );

   axi_rd_beat_tracker i_axi_rd_beat_tracker (
      .clk        (clk),
      .rst        (rst),
      .issue      (issue),
      .beat       (beat),
      .len_q      (len_q),
      .rlast      (m_r.last),
      .final_beat (final_beat),
      .error      (error)
   );

endmodule

`default_nettype wire

// ==== sim/axi_rd_bridge_assertions.sv ====
`timescale 1ns/1ps
`default_nettype none

module axi_rd_bridge_assertions (
   input logic                clk,
   input logic                rst,
   input logic                ready,
   input logic                error,
   input axi_rd_pkg::axi_ar_t m_ar,
   input logic                m_arvalid,
   input logic                m_arready,
   input logic                m_rready
);

   // Number of failed assertions
   int unsigned fail_count = 0;

   // AR stays valid and unchanged until the slave takes it
   arvalid_hold: assert property (@(posedge clk) disable iff (rst)
      m_arvalid && !m_arready |=> m_arvalid && $stable(m_ar))
   else begin
      $error("arvalid dropped or AR payload changed before arready");
      fail_count++;
   end

   // No data is taken while the bridge reports idle
   ready_low_in_data: assert property (@(posedge clk) disable iff (rst)
      m_rready |-> !ready)
   else begin
      $error("ready is high while m_rready is high");
      fail_count++;
   end

   // error only moves together with the end of a burst
   error_at_burst_end: assert property (@(posedge clk) disable iff (rst)
      $changed(error) |-> $rose(ready))
   else begin
      $error("error changed without ready rising");
      fail_count++;
   end

endmodule

bind axi_rd_bridge axi_rd_bridge_assertions i_axi_rd_bridge_assertions (
   .clk       (clk),
   .rst       (rst),
   .ready     (ready),
   .error     (error),
   .m_ar      (m_ar),
   .m_arvalid (m_arvalid),
   .m_arready (m_arready),
   .m_rready  (m_rready)
);

`default_nettype wire

// ==== sim/axi_rd_bridge_tb.sv ====
`timescale 1ns/1ps
`default_nettype none

`include "axi_rd_settings.svh"

module axi_rd_bridge_tb;

   logic                      clk = 1'b0;
   logic                      rst;
   logic [`AXI_RD_LEN_W-1:0]  length;
   logic                      s_valid;
   logic [`AXI_RD_ADDR_W-1:0] s_addr;
   logic                      ready;
   logic                      error;
   logic [`AXI_RD_DATA_W-1:0] s_rdata;
   logic                      s_ready;
   axi_rd_pkg::axi_ar_t       m_ar;
   logic                      m_arvalid;
   logic                      m_arready = 1'b0;
   axi_rd_pkg::axi_r_t        m_r = '0;
   logic                      m_rvalid = 1'b0;
   logic                      m_rready;

   // Burst the slave model is set up for
   logic [`AXI_RD_ADDR_W-1:0] cur_addr = '0;
   logic [`AXI_RD_LEN_W-1:0]  cur_len = '0;
   int unsigned               cur_mode = 0;
   int unsigned               cur_delay = 0;

   // Slave model state
   logic                      slv_busy = 1'b0;
   logic [`AXI_RD_ADDR_W-1:0] slv_addr = '0;
   logic [`AXI_RD_LEN_W-1:0]  slv_len = '0;
   int unsigned               beat_idx = 0;
   int unsigned               ar_wait = 0;

   // Separate random streams for the slave and the client
   integer                    slave_seed = 32'he97f;
   integer                    client_seed = 32'he97f;

   always #50 clk = ~clk;

   axi_rd_bridge i_axi_rd_bridge (
      .clk       (clk),
      .rst       (rst),
      .length    (length),
      .s_valid   (s_valid),
      .s_addr    (s_addr),
      .ready     (ready),
      .error     (error),
      .s_rdata   (s_rdata),
      .s_ready   (s_ready),
      .m_ar      (m_ar),
      .m_arvalid (m_arvalid),
      .m_arready (m_arready),
      .m_r       (m_r),
      .m_rvalid  (m_rvalid),
      .m_rready  (m_rready)
   );

   task automatic stop_with_failure();
      $display("Simulation FAILED");
      $fatal(1, "run stopped at the first failure");
   endtask

   task automatic check_value(input logic [63:0] actual, input logic [63:0] expected,
                              input string what);
      if (actual !== expected) begin
         $display("error at time %0t: %s is %0h, expected %0h", $time, what, actual, expected);
         stop_with_failure();
      end
   endtask

   task automatic report_timeout(input string what, input int unsigned cycles);
      $display("Timeout: %s did not happen within %0d clock cycles", what, cycles);
      stop_with_failure();
   endtask

   // rlast on beat idx for each rlast mode
   function automatic logic model_rlast(input int unsigned mode, input int unsigned idx,
                                        input int unsigned len);
      case (mode)
         1: model_rlast = 1'b0;
         2: model_rlast = (len > 0) && (idx == len - 1);
         default: model_rlast = (idx == len);
      endcase
   endfunction

   // Present beat idx, or leave a gap now and then
   task automatic offer_beat(input int unsigned idx);
      if (($random(slave_seed) & 3) != 0) begin
         m_rvalid <= 1'b1;
         m_r.data <= slv_addr + 4 * idx;
         m_r.last <= model_rlast(cur_mode, idx, slv_len);
      end else begin
         m_rvalid <= 1'b0;
      end
   endtask

   // AXI slave memory model, one burst at a time
   always @(posedge clk) begin
      if (rst) begin
         m_arready <= 1'b0;
         m_rvalid  <= 1'b0;
         slv_busy  <= 1'b0;
         ar_wait   <= 0;
      end else if (!slv_busy) begin
         if (m_arvalid && m_arready) begin
            check_value(m_ar.addr, cur_addr, "AR address");
            check_value(m_ar.len, cur_len, "AR length");
            check_value(m_ar.burst, axi_rd_pkg::burst_incr, "AR burst type");
            check_value(m_ar.size, 2, "AR size");
            check_value(m_ar.id, 0, "AR id");
            check_value(m_ar.lock, 0, "AR lock");
            check_value(m_ar.cache, 2, "AR cache");
            check_value(m_ar.prot, 2, "AR prot");
            check_value(m_ar.qos, 0, "AR qos");
            m_arready <= 1'b0;
            slv_busy  <= 1'b1;
            slv_addr  <= m_ar.addr;
            slv_len   <= m_ar.len;
            beat_idx  <= 0;
            ar_wait   <= 0;
         end else if (m_arvalid || ar_wait != 0) begin
            // Once raised, arvalid has to stay up until arready
            check_value(m_arvalid, 1, "m_arvalid before arready");
            ar_wait   <= ar_wait + 1;
            m_arready <= (ar_wait + 1 >= cur_delay);
         end else begin
            // Zero delay means arready is already up when arvalid rises
            m_arready <= (cur_delay == 0);
         end
      end else if (m_rvalid && m_rready) begin
         if (beat_idx == slv_len) begin
            m_rvalid <= 1'b0;
            slv_busy <= 1'b0;
         end else begin
            beat_idx <= beat_idx + 1;
            offer_beat(beat_idx + 1);
         end
      end else if (!m_rvalid) begin
         offer_beat(beat_idx);
      end
   end

   // One burst from the client side, ends with ready high again
   task automatic run_burst(input logic [`AXI_RD_ADDR_W-1:0] addr,
                            input logic [`AXI_RD_LEN_W-1:0] len,
                            input int unsigned mode, input int unsigned delay,
                            input logic hold_err);
      int unsigned               rx;
      int unsigned               cycles;
      int unsigned               limit;
      logic                      done;
      logic [`AXI_RD_DATA_W-1:0] exp_data;

      rx     = 0;
      cycles = 0;
      limit  = 8 * (len + 1) + delay + 64;
      done   = 1'b0;

      // Slave model gets its settings a cycle before the request
      @(posedge clk);
      cur_addr  <= addr;
      cur_len   <= len;
      cur_mode  <= mode;
      cur_delay <= delay;
      @(posedge clk);
      s_addr  <= addr;
      length  <= len;
      s_valid <= 1'b1;

      while (!done) begin
         @(posedge clk);
         cycles++;
         if (cycles > limit) begin
            report_timeout("last beat of the burst", limit);
         end
         if (cycles > 1) begin
            check_value(ready, 0, "ready during burst");
         end
         check_value(error, hold_err, "error during burst");
         if (s_valid && s_ready) begin
            exp_data = addr + 4 * rx;
            check_value(s_rdata, exp_data, "beat data");
            rx++;
         end
         if (rx == len + 1) begin
            // Drop s_valid now so the idle FSM does not issue again
            s_valid <= 1'b0;
            done = 1'b1;
         end else begin
            s_valid <= (($random(client_seed) % 5) != 0);
         end
      end

      cycles = 0;
      while (!ready) begin
         @(posedge clk);
         cycles++;
         if (!ready && cycles >= 4) begin
            report_timeout("ready after the last beat", 4);
         end
      end
   endtask

   initial begin
      int                        fd;
      int                        bursts;
      logic [8*128-1:0]          line;
      logic [`AXI_RD_ADDR_W-1:0] v_addr;
      logic [`AXI_RD_LEN_W-1:0]  v_len;
      int unsigned               v_mode;
      int unsigned               v_delay;
      logic                      v_err;
      logic                      prev_err;

      rst      = 1'b1;
      s_valid  = 1'b0;
      s_addr   = '0;
      length   = '0;
      bursts   = 0;
      prev_err = 1'b0;

      repeat (5) @(posedge clk);
      rst <= 1'b0;
      @(posedge clk);
      check_value(ready, 1, "ready after reset");
      check_value(error, 0, "error after reset");
      check_value(m_arvalid, 0, "m_arvalid after reset");

      fd = $fopen("sim/axi_rd_vectors.txt", "r");
      if (fd == 0) begin
         $display("Could not open the vector file sim/axi_rd_vectors.txt");
         stop_with_failure();
      end

      // Lines that do not give all five columns are comments
      while (!$feof(fd)) begin
         line = '0;
         if ($fgets(line, fd) > 0 &&
             $sscanf(line, "%h %d %d %d %d", v_addr, v_len, v_mode, v_delay, v_err) == 5) begin
            run_burst(v_addr, v_len, v_mode, v_delay, prev_err);
            check_value(error, v_err, "error after burst");
            prev_err = v_err;
            bursts++;
         end
      end
      $fclose(fd);

      if (bursts == 0) begin
         $display("The vector file holds no bursts");
         stop_with_failure();
      end else if (i_axi_rd_bridge.i_axi_rd_bridge_assertions.fail_count != 0) begin
         $display("%0d assertion failures were seen",
                  i_axi_rd_bridge.i_axi_rd_bridge_assertions.fail_count);
         stop_with_failure();
      end else begin
         $display("Simulation PASSED");
         $finish;
      end
   end

endmodule

`default_nettype wire

// ==== sim/axi_rd_vectors.txt ====
# One burst per line: address (hex), length = beats-1, rlast mode, arready delay, error
# rlast mode 0 marks the final beat, 1 never drives it, 2 drives it one beat early
00001000 0 0 0 0
00002000 3 0 1 0
00003000 7 1 0 1
00004000 1 2 2 1
00005010 15 0 3 0
00006000 0 1 1 1
00007000 0 2 0 1
00008000 2 0 5 0
00009000 5 2 1 1
0000a000 31 0 0 0
0000b000 4 1 4 1
0000c000 1 0 2 0
0000d100 9 2 0 1
0000e000 63 0 1 0
0000f000 2 1 0 1
00010000 0 0 7 0
7ffffff0 3 0 2 0
00011000 255 0 1 0
00012000 7 2 3 1
00013000 1 0 0 0
00014000 11 1 2 1
00015000 6 0 0 0

// ==== filelist.f ====
+incdir+hdl
hdl/axi_rd_pkg.sv
hdl/axi_rd_ctrl.sv
hdl/axi_ar_channel.sv
hdl/axi_rd_beat_tracker.sv
hdl/axi_rd_bridge.sv
sim/axi_rd_bridge_assertions.sv
sim/axi_rd_bridge_tb.sv

// ==== Makefile ====
VERILATOR := verilator
TOP       := axi_rd_bridge_tb
FILELIST  := filelist.f
OBJ_DIR   := obj_dir
VFLAGS    := --binary --timing --assert -Wno-fatal --top-module $(TOP) --Mdir $(OBJ_DIR)
PASS_MSG  := Simulation PASSED

.PHONY: help test clean

help:
	@echo "Targets:"
	@echo "  test   build the testbench with Verilator and run it"
	@echo "  clean  remove the Verilator build directory"
	@echo "  help   show this list"

test:
	$(VERILATOR) $(VFLAGS) -f $(FILELIST)
	@out="$$(./$(OBJ_DIR)/V$(TOP))"; \
	echo "$$out"; \
	echo "$$out" | grep -qF "$(PASS_MSG)"

clean:
	rm -rf $(OBJ_DIR)
